// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vfixp_top
FILELIST  ?= vfixp_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the console only, the status comes from the search
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src/vcsr_pkg.sv
// Only the fixed-point CSRs are described; vcsr keeps vxrm in bits 2:1 and vxsat in bit 0
package vcsr_pkg;

    localparam int CSR_ADDR_W = 12;

    // CSR numbers from the vector spec
    localparam logic [CSR_ADDR_W-1:0] CSR_VXSAT = 12'h009;
    localparam logic [CSR_ADDR_W-1:0] CSR_VXRM  = 12'h00A;
    localparam logic [CSR_ADDR_W-1:0] CSR_VCSR  = 12'h00F;

    // Fixed-point rounding mode
    typedef enum logic [1:0] {
        RNU_V = 2'b00,  // Round to nearest, ties up
        RNE_V = 2'b01,  // Round to nearest, ties even
        RDN_V = 2'b10,  // Truncate
        ROD_V = 2'b11   // Round to odd
    } vxrm_t;

    // vcsr as one raw word or as its two fields
    typedef union packed {
        logic [2:0] raw;
        struct packed {
            vxrm_t vxrm;
            logic  vxsat;
        } fields;
    } vcsr_t;

endpackage

// File: src/vec_pkg.sv
// Covers a single 64-bit register word only; element widths stop at 64 bits and there is no LMUL or masking
package vec_pkg;

    localparam int ELEN   = 64;              // Widest element, also the word size
    localparam int NBYTES = ELEN / 8;        // Byte adders per word
    localparam int BIDX_W = $clog2(NBYTES);  // Byte index inside one word

    typedef logic [ELEN-1:0] bus64_t;

    // Fixed-point add/subtract operations handled by this slice
    typedef enum logic [3:0] {
        VSADDU = 4'd0,
        VSADD  = 4'd1,
        VSSUBU = 4'd2,
        VSSUB  = 4'd3,
        VAADDU = 4'd4,
        VAADD  = 4'd5,
        VASUBU = 4'd6,
        VASUB  = 4'd7,
        NOP    = 4'd8
    } instr_type_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

endpackage

// File: src/vfixp_csr.sv
// vxsat is sticky; a saturation on the same edge as a CSR write still sets it
`timescale 1ns/100ps

module vfixp_csr (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            csr_we_i,
    input  logic [vcsr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  vec_pkg::bus64_t                 csr_wdata_i,
    input  logic                            sat_set_i,    // Saturation seen in the unit
    output vec_pkg::bus64_t                 csr_rdata_o,  // Combinational read
    output vcsr_pkg::vxrm_t                 vxrm_o
);

    import vcsr_pkg::*;

    vcsr_t csr_q;
    vcsr_t csr_d;

    // Write decode, each address touches only its own field
    always_comb begin
        csr_d = csr_q;
        if (csr_we_i) begin
            case (csr_addr_i)
                CSR_VXSAT: csr_d.fields.vxsat = csr_wdata_i[0];
                CSR_VXRM:  csr_d.fields.vxrm  = vxrm_t'(csr_wdata_i[1:0]);
                CSR_VCSR:  csr_d.raw          = csr_wdata_i[2:0];
                default:   csr_d              = csr_q;
            endcase
        end
        csr_d.fields.vxsat = csr_d.fields.vxsat | sat_set_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_q.fields.vxrm  <= RNU_V;
            csr_q.fields.vxsat <= 1'b0;
        end else begin
            csr_q <= csr_d;
        end
    end

    // Same word read as fields or as raw vcsr
    always_comb begin
        csr_rdata_o = '0;
        case (csr_addr_i)
            CSR_VXSAT: csr_rdata_o[0]   = csr_q.fields.vxsat;
            CSR_VXRM:  csr_rdata_o[1:0] = csr_q.fields.vxrm;
            CSR_VCSR:  csr_rdata_o[2:0] = csr_q.raw;
            default:   csr_rdata_o      = '0;  // Unknown CSR
        endcase
    end

    assign vxrm_o = csr_q.fields.vxrm;

endmodule

// File: src/vfixp_top.sv
// Result appears two edges after valid_i; the consumer must take every valid_o pulse
`timescale 1ns/100ps

module vfixp_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // CSR access
    input  logic                            csr_we_i,
    input  logic [vcsr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  vec_pkg::bus64_t                 csr_wdata_i,
    output vec_pkg::bus64_t                 csr_rdata_o,
    // Operation issue
    input  logic                            valid_i,
    input  vec_pkg::instr_type_t            instr_i,
    input  vec_pkg::sew_t                   sew_i,
    input  vec_pkg::bus64_t                 vs1_i,
    input  vec_pkg::bus64_t                 vs2_i,
    // Result
    output logic                            valid_o,
    output vec_pkg::bus64_t                 vd_o,
    output logic                            sat_o
);

    import vcsr_pkg::*;

    vxrm_t vxrm;     // Rounding mode to the unit
    logic  sat_set;  // Sets the sticky vxsat

    vfixp_csr vfixp_csr_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .sat_set_i   (sat_set),
        .csr_rdata_o (csr_rdata_o),
        .vxrm_o      (vxrm)
    );

    vfixp_unit vfixp_unit_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .instr_i   (instr_i),
        .sew_i     (sew_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .vxrm_i    (vxrm),
        .valid_o   (valid_o),
        .vd_o      (vd_o),
        .sat_o     (sat_o),
        .sat_set_o (sat_set)
    );

endmodule

// File: src/vfixp_unit.sv
// Fixed two-edge latency, one issue per cycle allowed, no back-pressure on the result
`timescale 1ns/100ps

module vfixp_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,    // One-cycle issue strobe
    input  vec_pkg::instr_type_t instr_i,
    input  vec_pkg::sew_t        sew_i,
    input  vec_pkg::bus64_t      vs1_i,
    input  vec_pkg::bus64_t      vs2_i,
    input  vcsr_pkg::vxrm_t      vxrm_i,     // Current CSR value
    output logic                 valid_o,
    output vec_pkg::bus64_t      vd_o,
    output logic                 sat_o,      // Aligned with vd_o
    output logic                 sat_set_o   // Early copy for the sticky vxsat
);

    import vec_pkg::*;
    import vcsr_pkg::*;

    // Issue stage
    logic        iss_valid_q;
    instr_type_t iss_instr_q;
    sew_t        iss_sew_q;
    bus64_t      iss_vs1_q;
    bus64_t      iss_vs2_q;
    vxrm_t       iss_vxrm_q;  // Mode in force at the issue edge

    bus64_t      alu_vd;
    logic        alu_sat;

    // Result stage
    logic        res_valid_q;
    bus64_t      res_vd_q;
    logic        res_sat_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_valid_q <= 1'b0;
        end else begin
            iss_valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            iss_instr_q <= instr_i;
            iss_sew_q   <= sew_i;
            iss_vs1_q   <= vs1_i;
            iss_vs2_q   <= vs2_i;
            iss_vxrm_q  <= vxrm_i;
        end
    end

    vsaaddsub vsaaddsub_inst (
        .instr_type_i (iss_instr_q),
        .sew_i        (iss_sew_q),
        .vxrm_i       (iss_vxrm_q),
        .data_vs1_i   (iss_vs1_q),
        .data_vs2_i   (iss_vs2_q),
        .data_vd_o    (alu_vd),
        .sat_ovf_o    (alu_sat)
    );

    // Reaches the CSR block on the same edge as the result register
    assign sat_set_o = iss_valid_q & alu_sat;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
            res_vd_q    <= '0;
            res_sat_q   <= 1'b0;
        end else begin
            res_valid_q <= iss_valid_q;
            res_sat_q   <= sat_set_o;
            if (iss_valid_q) begin
                res_vd_q <= alu_vd;  // Held until the next result
            end
        end
    end

    assign valid_o = res_valid_q;
    assign vd_o    = res_vd_q;
    assign sat_o   = res_sat_q;

endmodule

// File: src/vsaaddsub.sv
// Purely combinational over one 64-bit word; NOP and unknown op codes return zero with no saturation
`timescale 1ns/100ps

module vsaaddsub (
    input  vec_pkg::instr_type_t instr_type_i,  // Operation to perform
    input  vec_pkg::sew_t        sew_i,         // Element width
    input  vcsr_pkg::vxrm_t      vxrm_i,        // Rounding for the averaging forms
    input  vec_pkg::bus64_t      data_vs1_i,    // Subtrahend for the sub forms
    input  vec_pkg::bus64_t      data_vs2_i,
    output vec_pkg::bus64_t      data_vd_o,
    output logic                 sat_ovf_o      // At least one element was clipped
);

    import vec_pkg::*;
    import vcsr_pkg::*;

    logic                   is_sub;
    logic                   is_unsigned;
    logic                   is_avg;
    logic                   is_sat;
    logic [BIDX_W-1:0]      lane_mask;  // Byte index bits that stay inside one element
    logic [NBYTES-1:0]      first_b;    // Lowest byte of its element
    logic [NBYTES-1:0]      top_b;      // Highest byte of its element
    bus64_t                 opa;
    logic [NBYTES-1:0][8:0] sum9;       // Byte sums, carry out in bit 8
    logic [NBYTES-1:0]      ext;        // Bit above the element MSB
    logic [NBYTES-1:0]      ovf;
    bus64_t                 sum_w;      // Truncated element sums
    bus64_t                 shr_w;      // Wide sums shifted right by one
    bus64_t                 avg_w;

    assign is_sub      = instr_type_i inside {VSSUBU, VSSUB, VASUBU, VASUB};
    assign is_unsigned = instr_type_i inside {VSADDU, VSSUBU, VAADDU, VASUBU};
    assign is_avg      = instr_type_i inside {VAADDU, VAADD, VASUBU, VASUB};
    assign is_sat      = instr_type_i inside {VSADDU, VSADD, VSSUBU, VSSUB};

    always_comb begin
        case (sew_i)
            SEW_8:   lane_mask = BIDX_W'(0);
            SEW_16:  lane_mask = BIDX_W'(1);
            SEW_32:  lane_mask = BIDX_W'(3);
            default: lane_mask = '1;  // SEW_64
        endcase
    end

    // Element boundaries inside the word
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            first_b[i] = ((BIDX_W'(i) & lane_mask) == '0);
            top_b[i]   = ((BIDX_W'(i) & lane_mask) == lane_mask);
        end
    end

    // vs2 - vs1 as vs2 + ~vs1 + 1
    assign opa = is_sub ? ~data_vs1_i : data_vs1_i;

    // SIMD carry chain, restarted at each element
    always_comb begin
        logic cy;
        cy = 1'b0;
        for (int i = 0; i < NBYTES; i++) begin
            sum9[i] = {1'b0, opa[8*i +: 8]} + {1'b0, data_vs2_i[8*i +: 8]}
                      + 9'(first_b[i] ? is_sub : cy);
            cy      = sum9[i][8];
        end
    end

    // Extension bit and overflow, meaningful on the top byte of an element
    always_comb begin
        logic ea;
        logic eb;
        for (int i = 0; i < NBYTES; i++) begin
            // Zero extension for unsigned, inverted along with vs1 on subtract
            ea              = is_unsigned ? is_sub : opa[8*i+7];
            eb              = is_unsigned ? 1'b0 : data_vs2_i[8*i+7];
            ext[i]          = ea ^ eb ^ sum9[i][8];
            sum_w[8*i +: 8] = sum9[i][7:0];
            if (is_unsigned) begin
                ovf[i] = is_sat & ext[i];                  // Carry out, or borrow on sub
            end else begin
                ovf[i] = is_sat & (ext[i] ^ sum9[i][7]);   // Sign lost to truncation
            end
        end
    end

    // Averaging: halve the wider sum, then add the rounding increment
    always_comb begin
        logic cy;
        logic lost;
        logic keep;
        shr_w = {1'b0, sum_w[ELEN-1:1]};
        cy    = 1'b0;
        for (int i = 0; i < NBYTES; i++) begin
            if (top_b[i]) begin
                shr_w[8*i+7] = ext[i];  // MSB comes from the extension bit
            end
        end
        for (int i = 0; i < NBYTES; i++) begin
            lost = sum_w[8*i];    // Bit shifted out
            keep = sum_w[8*i+1];  // New LSB
            if (first_b[i]) begin
                case (vxrm_i)
                    RNU_V:   cy = lost;
                    RNE_V:   cy = lost & keep;
                    RDN_V:   cy = 1'b0;
                    default: cy = lost & ~keep;  // ROD_V jams the LSB
                endcase
            end
            {cy, avg_w[8*i +: 8]} = {1'b0, shr_w[8*i +: 8]} + 9'(cy);
        end
    end

    // Per-byte result select, saturation limit taken from the element's top byte
    always_comb begin
        logic [BIDX_W-1:0] top_idx;
        logic              neg;
        for (int i = 0; i < NBYTES; i++) begin
            top_idx = BIDX_W'(i) | lane_mask;
            neg     = ext[top_idx];  // True sign of a signed overflow
            if (is_avg) begin
                data_vd_o[8*i +: 8] = avg_w[8*i +: 8];
            end else if (ovf[top_idx]) begin
                if (is_unsigned) begin
                    data_vd_o[8*i +: 8] = {8{~is_sub}};  // All ones or zero
                end else if (top_b[i]) begin
                    data_vd_o[8*i +: 8] = {neg, {7{~neg}}};  // 0x80 or 0x7F
                end else begin
                    data_vd_o[8*i +: 8] = {8{~neg}};
                end
            end else if (is_sat) begin
                data_vd_o[8*i +: 8] = sum_w[8*i +: 8];
            end else begin
                data_vd_o[8*i +: 8] = 8'h00;
            end
        end
    end

    assign sat_ovf_o = |(ovf & top_b);

endmodule

// File: verif/tb_vfixp_top.sv
// Directed checks only; the back-to-back and same-edge checks assume a two-edge result latency
`timescale 1ns/100ps

module tb_vfixp_top;

    import vec_pkg::*;
    import vcsr_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 5;   // Input skew after the rising edge
    localparam int TIMEOUT    = 20;  // Cycles allowed for valid_o
    localparam int NCASES     = 24;

    // One table row
    typedef struct packed {
        instr_type_t instr;
        sew_t        sew;
        vxrm_t       vxrm;
        bus64_t      vs1;
        bus64_t      vs2;
        bus64_t      vd;   // Expected result
        logic        sat;  // Expected saturation flag
    } row_t;

    logic                  clk_i = 1'b0;
    logic                  rst_n_i;
    logic                  csr_we_i;
    logic [CSR_ADDR_W-1:0] csr_addr_i;
    bus64_t                csr_wdata_i;
    bus64_t                csr_rdata_o;
    logic                  valid_i;
    instr_type_t           instr_i;
    sew_t                  sew_i;
    bus64_t                vs1_i;
    bus64_t                vs2_i;
    logic                  valid_o;
    bus64_t                vd_o;
    logic                  sat_o;

    row_t  rows  [NCASES];
    string names [NCASES];
    int    n_rows;
    int    tests_run;
    int    tests_failed;

    vfixp_top vfixp_top_inst (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic compare_value(input string name, input bus64_t exp, input bus64_t act);
        tests_run++;
        if (act !== exp) begin
            tests_failed++;
            $display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
        end else begin
            $display("Pass %s", name);
        end
    endtask

    task automatic add_case(input string name, input row_t row);
        names[n_rows] = name;
        rows[n_rows]  = row;
        n_rows++;
    endtask

    task automatic drive_op(input instr_type_t instr, input sew_t sew,
                            input bus64_t vs1, input bus64_t vs2);
        valid_i = 1'b1;
        instr_i = instr;
        sew_i   = sew;
        vs1_i   = vs1;
        vs2_i   = vs2;
    endtask

    // Issue one operation and wait for its result
    task automatic run_op(input string name, input instr_type_t instr, input sew_t sew,
                          input bus64_t vs1, input bus64_t vs2,
                          output bus64_t vd, output logic sat);
        int waited;
        next_cycle();
        drive_op(instr, sew, vs1, vs2);
        next_cycle();
        valid_i = 1'b0;
        waited  = 0;
        while (valid_o !== 1'b1 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (valid_o !== 1'b1) begin
            $display("Timeout: %s gave no result within %0d cycles", name, TIMEOUT);
            tests_run++;
            tests_failed++;
        end
        vd  = vd_o;
        sat = sat_o;
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input bus64_t data);
        next_cycle();
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        next_cycle();  // Write lands on this edge
        csr_we_i    = 1'b0;
    endtask

    task automatic csr_check(input string name, input logic [CSR_ADDR_W-1:0] addr,
                             input bus64_t exp);
        csr_addr_i = addr;
        #1;  // Combinational read settles
        compare_value(name, exp, csr_rdata_o);
    endtask

    task automatic result_check(input string name, input bus64_t exp);
        compare_value({name, " valid"}, 64'h1, 64'(valid_o));
        compare_value({name, " vd"}, exp, vd_o);
    endtask

    task automatic fill_table();
        add_case("vsaddu_8_sat", row_t'{VSADDU, SEW_8, RNU_V, 64'h01, 64'hFF, 64'hFF, 1'b1});
        add_case("vsaddu_16_carry", row_t'{VSADDU, SEW_16, RNU_V, 64'h1, 64'hFF, 64'h100, 1'b0});
        add_case("vsaddu_32_sat",
                 row_t'{VSADDU, SEW_32, RNU_V, 64'h2, 64'hFFFF_FFFF, 64'hFFFF_FFFF, 1'b1});
        add_case("vsaddu_64",
                 row_t'{VSADDU, SEW_64, RNU_V, 64'h1, 64'hFFFF_FFFF, 64'h1_0000_0000, 1'b0});
        add_case("vssubu_8_sat", row_t'{VSSUBU, SEW_8, RNU_V, 64'h02, 64'h01, 64'h00, 1'b1});
        add_case("vssubu_16", row_t'{VSSUBU, SEW_16, RNU_V, 64'h1, 64'h100, 64'hFF, 1'b0});
        add_case("vssubu_32", row_t'{VSSUBU, SEW_32, RNU_V, 64'h1, 64'h1_0000, 64'hFFFF, 1'b0});
        add_case("vssubu_64_sat", row_t'{VSSUBU, SEW_64, RNU_V, 64'h1, 64'h0, 64'h0, 1'b1});
        add_case("vsadd_8_sat", row_t'{VSADD, SEW_8, RNU_V, 64'h01, 64'h7F, 64'h7F, 1'b1});
        add_case("vsadd_16_sat", row_t'{VSADD, SEW_16, RNU_V, 64'h1, 64'h7FFF, 64'h7FFF, 1'b1});
        add_case("vsadd_32", row_t'{VSADD, SEW_32, RNU_V, 64'hFFFF_FFFF, 64'h1, 64'h0, 1'b0});
        add_case("vsadd_64_sat", row_t'{VSADD, SEW_64, RNU_V, 64'h8000_0000_0000_0000,
                 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000, 1'b1});  // Stops at minimum
        add_case("vssub_8_sat", row_t'{VSSUB, SEW_8, RNU_V, 64'h01, 64'h80, 64'h80, 1'b1});
        add_case("vssub_16", row_t'{VSSUB, SEW_16, RNU_V, 64'h2, 64'h100, 64'hFE, 1'b0});
        add_case("vssub_32_sat", row_t'{VSSUB, SEW_32, RNU_V, 64'hFFFF_FFFF,
                 64'h7FFF_FFFF, 64'h7FFF_FFFF, 1'b1});
        add_case("vssub_64",
                 row_t'{VSSUB, SEW_64, RNU_V, 64'h7, 64'h5, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0});
        // 1 + 2 halves to 1.5 and each mode rounds it its own way
        add_case("vaaddu_rnu", row_t'{VAADDU, SEW_8, RNU_V, 64'h1, 64'h2, 64'h2, 1'b0});
        add_case("vaaddu_rne", row_t'{VAADDU, SEW_8, RNE_V, 64'h1, 64'h2, 64'h2, 1'b0});
        add_case("vaaddu_rdn", row_t'{VAADDU, SEW_8, RDN_V, 64'h1, 64'h2, 64'h1, 1'b0});
        add_case("vaaddu_rod", row_t'{VAADDU, SEW_8, ROD_V, 64'h1, 64'h2, 64'h1, 1'b0});
        // 1 + 4 halves to 2.5 and RNE rounds the tie to the even 2
        add_case("vaaddu_rne_even", row_t'{VAADDU, SEW_8, RNE_V, 64'h1, 64'h4, 64'h2, 1'b0});
        add_case("vaadd_8_neg_rod", row_t'{VAADD, SEW_8, ROD_V, 64'hFF, 64'hFE, 64'hFF, 1'b0});
        add_case("vasubu_32_rod", row_t'{VASUBU, SEW_32, ROD_V, 64'h7, 64'h10, 64'h5, 1'b0});
        add_case("vasub_64_rnu", row_t'{VASUB, SEW_64, RNU_V, 64'h1,
                 64'h8000_0000_0000_0000, 64'hC000_0000_0000_0000, 1'b0});
    endtask

    initial begin
        bus64_t vd;
        logic   sat;
        rst_n_i      = 1'b0;
        csr_we_i     = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        valid_i      = 1'b0;
        instr_i      = NOP;
        sew_i        = SEW_8;
        vs1_i        = '0;
        vs2_i        = '0;
        n_rows       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fill_table();
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;

        compare_value("reset valid_o", 64'h0, 64'(valid_o));
        csr_check("reset vcsr", CSR_VCSR, 64'h0);

        for (int i = 0; i < NCASES; i++) begin
            csr_write(CSR_VXRM, 64'(rows[i].vxrm));
            run_op(names[i], rows[i].instr, rows[i].sew, rows[i].vs1, rows[i].vs2, vd, sat);
            compare_value({names[i], " vd"}, rows[i].vd, vd);
            compare_value({names[i], " sat"}, 64'(rows[i].sat), 64'(sat));
        end

        // Sticky vxsat and the two views of vcsr
        csr_write(CSR_VXSAT, 64'h0);
        csr_check("vxsat cleared", CSR_VXSAT, 64'h0);
        run_op("vxsat set op", VSADDU, SEW_8, 64'h01, 64'hFF, vd, sat);
        csr_check("vxsat set", CSR_VXSAT, 64'h1);
        run_op("vxsat hold op", VSADDU, SEW_8, 64'h01, 64'h02, vd, sat);
        csr_check("vxsat sticky", CSR_VXSAT, 64'h1);
        csr_write(CSR_VXSAT, 64'h0);
        csr_check("vxsat write zero", CSR_VXSAT, 64'h0);
        csr_write(CSR_VCSR, 64'h5);           // vxrm RDN and vxsat set
        csr_check("vcsr to vxrm", CSR_VXRM, 64'h2);
        csr_check("vcsr to vxsat", CSR_VXSAT, 64'h1);
        csr_write(CSR_VCSR, 64'h0);

        // Three issues in a row with each result two edges later
        next_cycle();
        drive_op(VSADDU, SEW_8, 64'h01, 64'h02);
        next_cycle();
        drive_op(VSADD, SEW_16, 64'h0234, 64'h1000);
        compare_value("b2b no early result", 64'h0, 64'(valid_o));
        next_cycle();
        drive_op(VSSUBU, SEW_32, 64'h01, 64'h10);
        result_check("b2b first", 64'h03);
        next_cycle();
        valid_i = 1'b0;
        result_check("b2b second", 64'h1234);
        next_cycle();
        result_check("b2b third", 64'h0F);
        next_cycle();
        compare_value("b2b drained", 64'h0, 64'(valid_o));

        // vxrm write on the same edge as an averaging issue
        next_cycle();
        csr_we_i    = 1'b1;
        csr_addr_i  = CSR_VXRM;
        csr_wdata_i = 64'(RDN_V);
        drive_op(VAADDU, SEW_8, 64'h01, 64'h02);
        next_cycle();
        csr_we_i = 1'b0;
        drive_op(VAADDU, SEW_8, 64'h01, 64'h02);  // Sees RDN now
        next_cycle();
        valid_i = 1'b0;
        result_check("vxrm old mode", 64'h2);
        next_cycle();
        result_check("vxrm new mode", 64'h1);

        $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vfixp_top.f
src/vec_pkg.sv
src/vcsr_pkg.sv
src/vsaaddsub.sv
src/vfixp_csr.sv
src/vfixp_unit.sv
src/vfixp_top.sv
verif/tb_vfixp_top.sv
